//--- test/ipod_golden.txt
# op args: m = four memory words, c = ascii command, u/d/r = speed pulses
# q = quiet default periods, h = expected period, n = sample count then bytes
m 00020103 10121113 20222123 30323133
m 40424143 50525153 60626163 70727173
m 80828183 90929193 a0a2a1a3 b0b2b1b3
m c0c2c1c3 d0d2d1d3 e0e2e1e3 f0f2f1f3
q 3
h 8e0
c 45
n 3 00 01 10
c 44
q 4
c 45
n 3 11 20 21
c 42
n 4 30 31 20 21
n 4 10 11 00 01
n 4 f0 f1 e0 e1
c 46
n 4 d0 d1 e0 e1
n 4 f0 f1 00 01
u 3
h 7b4
n 4 10 11 20 21
d 1
h 818
r 1
h 8e0
n 4 30 31 40 41
u 19
h 110
n 4 50 51 60 61
r 1
d 19
h 10b0
n 2 70 71
r 1
h 8e0

//--- sim.f
design/ipod_pkg.sv
design/rate_control.sv
design/command_decoder.sv
design/flash_reader.sv
design/hex_display.sv
design/simple_ipod.sv
test/flash_model.sv
test/tb_simple_ipod.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log says so
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_simple_ipod -f sim.f
./obj_dir/Vtb_simple_ipod | tee sim.log
if grep -q "^Regression passed$" sim.log; then
  exit 0
else
  exit 1
fi

//--- test/tb_simple_ipod.sv
`timescale 1ns/1ns

module tb_simple_ipod import ipod_pkg::*;
();

  localparam int unsigned small_word_count = 16;
  localparam int max_period = 4272;
  localparam int timeout_factor = 2;

  // Active-low gfedcba patterns for digits 0 to F
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                   CLK_50M = 1'b0;
  logic                   reset;
  ascii_t                 ascii_code;
  logic                   ascii_valid;
  logic                   speed_up;
  logic                   speed_down;
  logic                   speed_reset;
  flash_req_t             flash_req;
  flash_rsp_t             flash_rsp;
  sample_t                sample;
  logic                   sample_valid;
  seg7_t [hex_digits-1:0] hex;

  sample_t     got_q [$];
  logic [7:0]  step_op;
  logic [31:0] step_arg [5];
  int          checks;
  int          errors;
  int          sample_index;
  int          read_cycles;
  int          limit_cycles;
  logic        limit_ready = 1'b0;

  simple_ipod #(
    .word_count (small_word_count)
  ) dut
  (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .ascii_code   (ascii_code),
    .ascii_valid  (ascii_valid),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .hex          (hex)
  );

  flash_model #(
    .depth (small_word_count)
  ) memory
  (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  always #10 CLK_50M = ~CLK_50M;

  // Every emitted sample is queued for the steps to consume in order
  always @(negedge CLK_50M)
  begin
    if (sample_valid)
      got_q.push_back(sample);
    if (flash_req.read)
      read_cycles++;
  end

  // ====================
  // Helpers
  // ====================

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [hex_digits*7-1:0] expected_hex(input logic [15:0] period);
    logic [hex_digits*4-1:0] digits;
    logic [hex_digits*7-1:0] segs;
    digits = {8'h00, period};
    for (int i = 0; i < hex_digits; i++)
      segs[i*7 +: 7] = seg_table[digits[i*4 +: 4]];
    return segs;
  endfunction

  // Splits the next non-comment golden line into an op letter and hex arguments
  task automatic read_step(input int fd, output logic found);
    string line;
    int    code;
    found = 1'b0;
    while (!found && !$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code > 1 && line[0] != "#")
      begin
        step_op = line[0];
        code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
          step_arg[0], step_arg[1], step_arg[2], step_arg[3], step_arg[4]);
        found = 1'b1;
      end
    end
  endtask

  task automatic send_command(input ascii_t code);
    ascii_code  = code;
    ascii_valid = 1'b1;
    @(negedge CLK_50M);
    ascii_valid = 1'b0;
  endtask

  task automatic pulse_speed(input logic [7:0] kind, input int count);
    repeat (count)
    begin
      speed_up    = (kind == "u");
      speed_down  = (kind == "d");
      speed_reset = (kind == "r");
      @(negedge CLK_50M);
      speed_up    = 1'b0;
      speed_down  = 1'b0;
      speed_reset = 1'b0;
      @(negedge CLK_50M);
    end
  endtask

  task automatic collect_samples(input int count);
    for (int i = 0; i < count; i++)
    begin
      while (got_q.size() == 0)
        @(negedge CLK_50M);
      compare_value($sformatf("sample %0d", sample_index), 64'(step_arg[i+1][7:0]),
        64'(got_q.pop_front()));
      sample_index++;
    end
  endtask

  task automatic run_step();
    int base;
    int base_reads;
    int quiet_cycles;
    case (step_op)
      "c": send_command(ascii_t'(step_arg[0]));
      "u", "d", "r": pulse_speed(step_op, step_arg[0]);
      "n": collect_samples(step_arg[0]);
      "q":
      begin
        // No sample and no memory read for this many default periods
        base = got_q.size();
        base_reads = read_cycles;
        quiet_cycles = int'(step_arg[0]) * int'(default_period);
        repeat (quiet_cycles) @(negedge CLK_50M);
        compare_value("quiet sample count", 64'(base), 64'(got_q.size()));
        compare_value("quiet read cycles", 64'(base_reads), 64'(read_cycles));
      end
      "h":
      begin
        // Offset, period and segment registers in a row
        repeat (4) @(negedge CLK_50M);
        compare_value($sformatf("hex period %0h", step_arg[0][15:0]),
          64'(expected_hex(step_arg[0][15:0])), 64'(hex));
      end
      default:
      begin
      end
    endcase
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    int   fd;
    int   total;
    logic found;
    checks       = 0;
    errors       = 0;
    sample_index = 0;
    read_cycles  = 0;
    reset        = 1'b1;
    ascii_code   = '0;
    ascii_valid  = 1'b0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    // Watchdog budget from samples and quiet periods in the file
    total = 8;
    fd = $fopen("test/ipod_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open test/ipod_golden.txt");
      errors++;
    end
    else
    begin
      found = 1'b1;
      while (found)
      begin
        read_step(fd, found);
        if (found && (step_op == "n" || step_op == "q"))
          total += step_arg[0];
      end
      $fclose(fd);
    end
    limit_cycles = total * max_period * timeout_factor;
    limit_ready  = 1'b1;
    repeat (8) @(negedge CLK_50M);
    reset = 1'b0;
    if (errors == 0)
    begin
      fd = $fopen("test/ipod_golden.txt", "r");
      found = 1'b1;
      while (found)
      begin
        read_step(fd, found);
        if (found)
          run_step();
      end
      $fclose(fd);
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge CLK_50M);
    $display("Timeout after %0d cycles, expected samples never arrived", limit_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- test/flash_model.sv
`timescale 1ns/1ns

module flash_model import ipod_pkg::*;
#(
  parameter int depth = 16
)
(
  input  logic       CLK_50M,
  input  logic       reset,
  input  flash_req_t flash_req,
  output flash_rsp_t flash_rsp
);

  flash_word_t mem [depth];
  integer      seed;
  int          stall;
  int          latency;
  int          phase;
  word_addr_t  addr;

  // Memory words come from the m lines of the golden file
  initial
  begin
    int          fd;
    int          code;
    int          count;
    int          fill;
    string       line;
    flash_word_t words [4];
    fill = 0;
    fd = $fopen("test/ipod_golden.txt", "r");
    if (fd == 0)
      $display("flash_model cannot open test/ipod_golden.txt");
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] == "m")
        begin
          count = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
            words[0], words[1], words[2], words[3]);
          for (int i = 0; i < count && fill < depth; i++)
          begin
            mem[fill] = words[i];
            fill++;
          end
        end
      end
      $fclose(fd);
    end
  end

  // ====================
  // Read bus responder
  // ====================

  // Responses change on the falling edge, the DUT samples on the rising one
  initial
  begin
    seed = 32'hae6a20b9;
    phase = 0;
    flash_rsp = '{waitrequest: 1'b1, readdatavalid: 1'b0, readdata: '0};
    forever
    begin
      @(negedge CLK_50M);
      flash_rsp.waitrequest   = 1'b1;
      flash_rsp.readdatavalid = 1'b0;
      if (reset)
        phase = 0;
      else
      begin
        // New read, pick a stall of 0 to 5 cycles
        if (phase == 0 && flash_req.read)
        begin
          stall = $unsigned($random(seed)) % 6;
          phase = 1;
        end
        if (phase == 1)
        begin
          if (stall == 0)
          begin
            flash_rsp.waitrequest = 1'b0;
            addr = flash_req.address;
            latency = $unsigned($random(seed)) % 6;
            phase = 2;
          end
          else
            stall--;
        end
        else if (phase == 2)
        begin
          if (latency == 0)
          begin
            flash_rsp.readdatavalid = 1'b1;
            flash_rsp.readdata      = mem[addr[$clog2(depth)-1:0]];
            phase = 0;
          end
          else
            latency--;
        end
      end
    end
  end

endmodule

//--- design/simple_ipod.sv
`timescale 1ns/1ns

module simple_ipod import ipod_pkg::*;
#(
  parameter int unsigned word_count = default_word_count
)
(
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  ascii_t                 ascii_code,
  input  logic                   ascii_valid,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_reset,
  output flash_req_t             flash_req,
  input  flash_rsp_t             flash_rsp,
  output sample_t                sample,
  output logic                   sample_valid,
  output seg7_t [hex_digits-1:0] hex
);

  period_t period;
  logic    sample_tick;
  logic    play;
  logic    forward;

  // ====================
  // Control
  // ====================

  rate_control u_rate_control
  (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period),
    .sample_tick (sample_tick)
  );

  command_decoder u_command_decoder
  (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .play        (play),
    .forward     (forward)
  );

  // ====================
  // Datapath
  // ====================

  flash_reader #(
    .word_count (word_count)
  ) u_flash_reader
  (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sample_tick  (sample_tick),
    .play         (play),
    .forward      (forward),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // Shows the current sample period
  hex_display u_hex_display
  (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .period  (period),
    .hex     (hex)
  );

endmodule

//--- design/hex_display.sv
`timescale 1ns/1ns

module hex_display import ipod_pkg::*;
(
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  period_t                period,
  output seg7_t [hex_digits-1:0] hex
);

  logic [hex_digits*4-1:0] nibbles;
  seg7_t [hex_digits-1:0]  digit_seg;

  // Hex digit to active-low segments, gfedcba
  function automatic seg7_t seg_decode(input logic [3:0] value);
    seg7_t seg;
    case (value)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // Upper two digits always read zero
  assign nibbles = {{(hex_digits*4-16){1'b0}}, period};

  always_comb
  begin
    for (int i = 0; i < hex_digits; i++)
      digit_seg[i] = seg_decode(nibbles[i*4 +: 4]);
  end

  // Blank display during reset
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      hex <= '1;
    else
      hex <= digit_seg;
  end

endmodule

//--- design/flash_reader.sv
`timescale 1ns/1ns

module flash_reader import ipod_pkg::*;
#(
  parameter int unsigned word_count = default_word_count
)
(
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       sample_tick,
  input  logic       play,
  input  logic       forward,
  output flash_req_t flash_req,
  input  flash_rsp_t flash_rsp,
  output sample_t    sample,
  output logic       sample_valid
);

  localparam word_addr_t last_addr = word_addr_t'(word_count - 1);

  reader_state_t state;
  word_addr_t    word_addr;
  word_addr_t    next_addr;
  flash_word_t   read_word;
  logic          lower_half;

  // ====================
  // Read bus
  // ====================

  // Read stays up until the memory drops waitrequest
  always_comb
  begin
    flash_req.read    = (state == request);
    flash_req.address = word_addr;
  end

  // Step one word in the current direction with wrap
  always_comb
  begin
    if (forward)
    begin
      if (word_addr == last_addr)
        next_addr = '0;
      else
        next_addr = word_addr + 23'd1;
    end
    else
    begin
      if (word_addr == '0)
        next_addr = last_addr;
      else
        next_addr = word_addr - 23'd1;
    end
  end

  // ====================
  // Read FSM
  // ====================

  // Ticks during request and wait_data are dropped
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state        <= idle;
      word_addr    <= '0;
      read_word    <= '0;
      lower_half   <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        idle:
        begin
          if (sample_tick && play)
            state <= request;
        end
        request:
        begin
          if (!flash_rsp.waitrequest)
            state <= wait_data;
        end
        wait_data:
        begin
          // Upper byte goes out as soon as the word lands
          if (flash_rsp.readdatavalid)
          begin
            read_word    <= flash_rsp.readdata;
            lower_half   <= 1'b0;
            sample_valid <= 1'b1;
            state        <= play_low;
          end
        end
        play_low:
        begin
          // Middle byte on the next tick, then move on
          if (sample_tick && play)
          begin
            lower_half   <= 1'b1;
            sample_valid <= 1'b1;
            word_addr    <= next_addr;
            state        <= idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // Half select on the captured word
  assign sample = lower_half ? read_word[15:8] : read_word[31:24];

endmodule

//--- design/command_decoder.sv
`timescale 1ns/1ns

module command_decoder import ipod_pkg::*;
(
  input  logic   CLK_50M,
  input  logic   reset,
  input  ascii_t ascii_code,
  input  logic   ascii_valid,
  output logic   play,
  output logic   forward
);

  // Playback flags, stopped and forward out of reset
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play    <= 1'b0;
      forward <= 1'b1;
    end
    else if (ascii_valid)
    begin
      case (ascii_code)
        cmd_play:
        begin
          play <= 1'b1;
        end
        cmd_stop:
        begin
          play <= 1'b0;
        end
        cmd_forward:
        begin
          forward <= 1'b1;
        end
        cmd_backward:
        begin
          forward <= 1'b0;
        end
        // Any other key is ignored
        default:
        begin
          play    <= play;
          forward <= forward;
        end
      endcase
    end
  end

endmodule

//--- design/rate_control.sv
`timescale 1ns/1ns

module rate_control import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    reset,
  input  logic    speed_up,
  input  logic    speed_down,
  input  logic    speed_reset,
  output period_t period,
  output logic    sample_tick
);

  speed_offset_t offset;
  speed_offset_t offset_faster;
  speed_offset_t offset_slower;
  period_t       count;
  period_t       cycle_period;

  // ====================
  // Speed offset
  // ====================

  // Shorter period means faster playback
  assign offset_faster = offset - speed_step;
  assign offset_slower = offset + speed_step;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      offset <= '0;
    end
    else if (speed_reset)
    begin
      offset <= '0;
    end
    else if (speed_up)
    begin
      if (offset_faster < -speed_limit)
        offset <= -speed_limit;
      else
        offset <= offset_faster;
    end
    else if (speed_down)
    begin
      if (offset_slower > speed_limit)
        offset <= speed_limit;
      else
        offset <= offset_slower;
    end
  end

  // Two's complement add, result always stays positive
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      period <= default_period;
    else
      period <= default_period + period_t'(offset);
  end

  // ====================
  // Sample divider
  // ====================

  // New period is picked up only at the wrap
  assign sample_tick = (count == cycle_period - 16'd1);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count        <= '0;
      cycle_period <= default_period;
    end
    else if (sample_tick)
    begin
      count        <= '0;
      cycle_period <= period;
    end
    else
    begin
      count <= count + 16'd1;
    end
  end

endmodule

//--- design/ipod_pkg.sv
package ipod_pkg;

  // ====================
  // Widths
  // ====================

  // Word address into the sample memory
  typedef logic [22:0] word_addr_t;

  // One memory word holds two 8-bit samples
  typedef logic [31:0] flash_word_t;
  typedef logic [7:0] sample_t;

  typedef logic [7:0] ascii_t;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;
  typedef logic signed [15:0] speed_offset_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg7_t;

  // ====================
  // Constants
  // ====================

  // Keyboard command codes
  localparam ascii_t cmd_play     = 8'h45;
  localparam ascii_t cmd_stop     = 8'h44;
  localparam ascii_t cmd_forward  = 8'h46;
  localparam ascii_t cmd_backward = 8'h42;

  // About 22 kHz at 50 MHz
  localparam period_t default_period = 16'd2272;
  localparam speed_offset_t speed_step = 16'sd100;
  localparam speed_offset_t speed_limit = 16'sd2000;

  localparam logic [31:0] default_word_count = 32'd524288;
  localparam int hex_digits = 6;

  // ====================
  // Bus and state types
  // ====================

  // Read request toward the memory
  typedef struct packed {
    logic       read;
    word_addr_t address;
  } flash_req_t;

  // Memory response, data valid for one cycle only
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  typedef enum logic [1:0] {
    idle,
    request,
    wait_data,
    play_low
  } reader_state_t;

endpackage
